// File: vlog.f
+incdir+logic
logic/fizzle_pkg.sv
logic/display_timing.sv
logic/framebuffer_ram.sv
logic/fizzle_fader.sv
logic/line_scaler.sv
logic/palette_lut.sv
logic/host_regs.sv
logic/fizzle_display_top.sv
bench/fizzle_properties.sv
bench/fizzle_tb.sv

// File: bench/fizzle_testdata.mem
// image: 8 rows of 16 colour indices, row major from pixel 0
// then 16 palette words (unused nibble, r, g, b)
// then probe ctrl, its read-back, fade ctrl, palette index, new palette word, fb read-back
3 1 2 3 4 5 6 7 8 9 A B C D E F
1 2 3 4 5 6 7 8 9 A B C D E F 0
0 0 F F 0 0 F F 0 0 F F 0 0 F F
5 5 5 5 A A A A 5 5 5 5 A A A A
7 6 5 4 3 2 1 0 F E D C B A 9 8
C C C C C C C C 2 2 2 2 2 2 2 2
9 3 9 3 9 3 9 3 9 3 9 3 9 3 9 3
E D C B A 9 8 7 6 5 4 3 2 1 0 E
// palette, entries 10 and 13 carry a nonzero unused nibble
0000 0F00 00F0 000F 0FF0 00FF 0F0F 0FFF 0888 0800 A080 0008 0880 5088 0808 0444
// fade ctrl 7003 is colour 7, 4 cycles per step
5001 5001 7003 5 0F84 0000

// File: bench/fizzle_tb.sv
// ******************************
// testbench for the fizzlefade display with stimulus from the bench data file
// loads image and palette over wishbone, captures frames and runs one fade
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module fizzle_tb;

    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
    localparam int NPIX      = `FB_WIDTH * `FB_HEIGHT;
    localparam int SET_BASE  = NPIX + 16;        // settings follow image and palette

    logic                   clk_sys;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`WB_ADRW-1:0]    wb_adr;
    fizzle_pkg::host_word_t wb_dat_w;
    fizzle_pkg::host_word_t wb_dat_r;
    logic                   wb_ack;
    logic                   fade_busy;
    logic                   vga_hsync;
    logic                   vga_vsync;
    logic [3:0]             vga_r;
    logic [3:0]             vga_g;
    logic [3:0]             vga_b;

    logic [15:0]            tdata [SET_BASE + 6];
    fizzle_pkg::cidx_t      img_m [NPIX];           // expected framebuffer
    fizzle_pkg::colr_t      pal_m [16];             // expected palette
    fizzle_pkg::colr_t      cap   [`V_ACTIVE][`H_ACTIVE];

    int   err_cnt;
    int   chk_cnt;
    int   test_no;
    int   test_err0;
    int   cyc_cnt;
    int   test_start_cyc;
    int   cyc_limit = 100000;                   // replaced once the data is read
    int   frames_done;
    int   hs_lines;
    int   hs_gap;
    int   px;
    int   py;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    bit   h_seen;
    bit   v_seen;

    fizzle_display_top UUT (
        .clk_sys, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .fade_busy, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

    always #20 clk_sys = ~clk_sys;              // 40 ns period

    // per-test watchdog
    always @(posedge clk_sys) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt - test_start_cyc > cyc_limit) begin
            $display("%0t ns: timeout, test %0d ran past %0d cycles", $time, test_no, cyc_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_colr(input string what, input fizzle_pkg::colr_t got,
                              input fizzle_pkg::colr_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s got %03h expected %03h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input fizzle_pkg::host_word_t got,
                              input fizzle_pkg::host_word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    // capture with the screen position rebuilt from the sync rises
    always @(negedge clk_sys) begin : capture
        fizzle_pkg::colr_t pix;
        int                px_n;
        int                py_n;
        pix  = {vga_r, vga_g, vga_b};
        px_n = (px == `H_TOTAL - 1) ? 0 : px + 1;
        py_n = py;
        if (px == `H_TOTAL - 1) begin
            py_n = (py == `V_TOTAL - 1) ? 0 : py + 1;
        end
        if (vga_hsync === 1'b1 && hs_prev === 1'b0) begin
            if (h_seen) begin
                hs_lines++;
                chk_cnt++;
                if (hs_gap != `H_TOTAL) begin
                    err_cnt++;
                    $display("Mismatch at %0t ns: hsync period got %0d expected %0d",
                             $time, hs_gap, `H_TOTAL);
                end
            end
            h_seen = 1'b1;
            hs_gap = 1;
            px_n   = `H_SYNC_START;               // rise marks sync start
        end else begin
            hs_gap++;
        end
        if (vga_vsync === 1'b1 && vs_prev === 1'b0) begin
            v_seen = 1'b1;
            py_n   = `V_SYNC_START;
        end
        if (h_seen && v_seen) begin
            if (px_n < `H_ACTIVE && py_n < `V_ACTIVE) begin
                cap[py_n][px_n] = pix;
                if (px_n == `H_ACTIVE - 1 && py_n == `V_ACTIVE - 1) begin
                    frames_done++;                // last active pixel stored
                end
            end else begin
                check_colr($sformatf("vga rgb blank (%0d,%0d)", px_n, py_n), pix, '0);
            end
        end
        px      = px_n;
        py      = py_n;
        hs_prev = vga_hsync;
        vs_prev = vga_vsync;
    end

    task automatic bus_transfer(input logic we, input logic [`WB_ADRW-1:0] adr,
                                input fizzle_pkg::host_word_t wdat,
                                output fizzle_pkg::host_word_t rdat);
        @(posedge clk_sys);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge clk_sys);
        while (wb_ack !== 1'b1) begin
            @(negedge clk_sys);                   // wait for the slave
        end
        rdat = wb_dat_r;
        @(posedge clk_sys);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk_sys);
        if (wb_ack !== 1'b0) begin
            err_cnt++;
            $display("%0t ns: wb_ack stayed high after the transfer at %02h", $time, adr);
        end
    endtask

    task automatic bus_write(input logic [`WB_ADRW-1:0] adr, input fizzle_pkg::host_word_t wdat);
        fizzle_pkg::host_word_t unused;
        bus_transfer(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [`WB_ADRW-1:0] adr, output fizzle_pkg::host_word_t rdat);
        bus_transfer(1'b0, adr, '0, rdat);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            @(negedge clk_sys);
        end
    endtask

    // screen pixel (x,y) shows image pixel (x/scale, y/scale)
    task automatic check_frame(input string tag);
        fizzle_pkg::colr_t exp;
        for (int y = 0; y < `V_ACTIVE; y++) begin
            for (int x = 0; x < `H_ACTIVE; x++) begin
                exp = pal_m[img_m[(y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE]];
                check_colr($sformatf("%s vga rgb (%0d,%0d)", tag, x, y), cap[y][x], exp);
            end
        end
    endtask

    task automatic open_test();
        test_no++;
        test_err0      = err_cnt;
        test_start_cyc = cyc_cnt;
    endtask

    task automatic close_test(input string name);
        $display("test %0d %s: %0d errors", test_no, name, err_cnt - test_err0);
    endtask

    initial begin
        fizzle_pkg::host_word_t word;
        fizzle_pkg::host_word_t exp;
        fizzle_pkg::cidx_t      pidx;
        int                     rate;
        int                     busy_cyc;
        int                     lines0;
        clk_sys  = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        $readmemh("bench/fizzle_testdata.mem", tdata);
        word      = tdata[SET_BASE + 2];
        rate      = int'(word.ctrl.rate);
        cyc_limit = 4 * FRAME_CYC + NPIX * (rate + 1) + 500;
        repeat (5) @(posedge clk_sys);
        #2 rst_n = 1'b1;
        @(negedge clk_sys);

        // control and palette read-back
        open_test();
        if (wb_ack !== 1'b0 || fade_busy !== 1'b0
            || vga_hsync !== 1'b0 || vga_vsync !== 1'b0) begin
            err_cnt++;
            $display("%0t ns: ack, fade_busy or a sync output not inactive after reset", $time);
        end
        check_colr("vga rgb after reset", {vga_r, vga_g, vga_b}, '0);
        bus_write(`REG_CTRL, tdata[SET_BASE]);
        bus_read(`REG_CTRL, word);
        check_word("wb_dat_r control", word, tdata[SET_BASE + 1]);
        while (fade_busy) begin
            @(negedge clk_sys);                   // probe write also runs a short fade
        end
        for (int i = 0; i < 16; i++) begin
            word     = tdata[NPIX + i];
            pal_m[i] = word.pal.colr;
            bus_write(8'(`PAL_BASE + i), word);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(8'(`PAL_BASE + i), word);
            exp          = '0;                    // top nibble reads as zero
            exp.pal.colr = pal_m[i];
            check_word($sformatf("wb_dat_r palette %0d", i), word, exp);
        end
        bus_read(`FB_BASE, word);
        check_word("wb_dat_r framebuffer", word, tdata[SET_BASE + 5]);
        close_test("register read-back");

        // image load shows from the frame after next
        open_test();
        for (int i = 0; i < NPIX; i++) begin
            img_m[i] = tdata[i][3:0];
            bus_write(8'(`FB_BASE + i), tdata[i]);
        end
        wait_frames(3);
        check_frame("image");
        close_test("image display");

        // blanking and line period are checked by the capture block
        open_test();
        lines0 = hs_lines;
        wait_frames(1);
        if (hs_lines == lines0) begin
            err_cnt++;
            $display("%0t ns: no hsync pulse seen during a whole frame", $time);
        end
        close_test("blanking and line period");

        // one palette entry rewritten
        open_test();
        pidx        = tdata[SET_BASE + 3][3:0];
        word        = tdata[SET_BASE + 4];
        pal_m[pidx] = word.pal.colr;
        bus_write(8'(`PAL_BASE + int'(pidx)), word);
        wait_frames(3);
        check_frame("palette change");
        close_test("palette change");

        // fade over every pixel but 0
        open_test();
        word = tdata[SET_BASE + 2];
        bus_write(`REG_CTRL, word);
        if (fade_busy !== 1'b1) begin
            err_cnt++;
            $display("%0t ns: fade_busy did not rise after the control write", $time);
        end
        busy_cyc = 0;
        while (fade_busy === 1'b1) begin
            @(negedge clk_sys);
            busy_cyc++;
        end
        chk_cnt++;
        if (busy_cyc < (NPIX - 2) * (rate + 1) || busy_cyc > NPIX * (rate + 1)) begin
            err_cnt++;                            // one step of slack each way
            $display("Mismatch at %0t ns: fade_busy cycles got %0d expected %0d",
                     $time, busy_cyc, (NPIX - 1) * (rate + 1));
        end
        for (int i = 1; i < NPIX; i++) begin
            img_m[i] = word.ctrl.idx;
        end
        wait_frames(3);
        check_frame("fade");
        close_test("fizzlefade");

        // failures of the bound assertions
        err_cnt += UUT.regs_inst.bus_props.fail_cnt + UUT.timing_inst.sync_props.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", test_no, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fizzle_properties.sv
// ******************************
// bus and sync assertions bound into host_regs and display_timing
// inputs a target lacks are tied off at its bind
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module fizzle_properties (
    input wire logic clk_sys,
    input wire logic rst_n,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_ack,
    input wire logic hsync
);

    localparam int HS_WIDTH = `H_SYNC_END - `H_SYNC_START;

    int fail_cnt = 0;    // failed assertions so far

    // ack answers a live request only
    ack_after_stb: assert property (@(posedge clk_sys) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fail_cnt++;
            $error("wb_ack without cyc and stb in the cycle before");
        end

    ack_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            fail_cnt++;
            $error("wb_ack held for more than one cycle");
        end

    // high exactly HS_WIDTH cycles before each fall
    hsync_width: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $fell(hsync) |-> $past(hsync, HS_WIDTH) && !$past(hsync, HS_WIDTH + 1))
        else begin
            fail_cnt++;
            $error("hsync pulse width is not %0d cycles", HS_WIDTH);
        end

endmodule

bind host_regs fizzle_properties bus_props (
    .clk_sys, .rst_n, .wb_cyc, .wb_stb, .wb_ack, .hsync (1'b0)
);

bind display_timing fizzle_properties sync_props (
    .clk_sys, .rst_n, .wb_cyc (1'b0), .wb_stb (1'b0), .wb_ack (1'b0), .hsync
);

`default_nettype wire

// File: logic/fizzle_display_top.sv
// ******************************
// fizzlefade framebuffer display, single clock
// host loads image and palette over wishbone, then starts the fade
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module fizzle_display_top (
    input  wire logic                    clk_sys,
    input  wire logic                    rst_n,
    input  wire logic                    wb_cyc,
    input  wire logic                    wb_stb,
    input  wire logic                    wb_we,
    input  wire logic [`WB_ADRW-1:0]     wb_adr,
    input  wire fizzle_pkg::host_word_t  wb_dat_w,
    output fizzle_pkg::host_word_t       wb_dat_r,
    output logic                         wb_ack,
    output logic                         fade_busy,
    output logic                         vga_hsync,
    output logic                         vga_vsync,
    output logic [3:0]                   vga_r,
    output logic [3:0]                   vga_g,
    output logic [3:0]                   vga_b
);

    // timing
    logic [5:0] sx;
    logic [5:0] sy;
    logic       de;
    logic       hsync;
    logic       vsync;
    logic       line_start;
    logic       frame_start;

    // host side
    logic                 fb_host_we;
    fizzle_pkg::fb_addr_t fb_host_addr;
    fizzle_pkg::cidx_t    fb_host_idx;
    logic                 pal_we;
    fizzle_pkg::cidx_t    pal_idx;
    fizzle_pkg::colr_t    pal_colr;
    fizzle_pkg::colr_t    pal_rd_colr;
    logic                 fade_start;
    logic [11:0]          fade_rate;
    fizzle_pkg::cidx_t    fade_idx;

    // fader and display path
    logic                 fade_we;
    fizzle_pkg::fb_addr_t fade_addr;
    fizzle_pkg::cidx_t    fade_wr_idx;
    fizzle_pkg::fb_addr_t fb_rd_addr;
    fizzle_pkg::cidx_t    fb_idx;
    fizzle_pkg::cidx_t    lb_idx;
    logic                 lb_valid;
    fizzle_pkg::colr_t    pix_colr;

    logic [1:0]           hs_pipe;   // syncs follow the 3 cycle colour path
    logic [1:0]           vs_pipe;

    display_timing timing_inst (
        .clk_sys, .rst_n, .sx, .sy, .de, .hsync, .vsync, .line_start, .frame_start
    );

    host_regs regs_inst (
        .clk_sys, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .pal_rd_colr,
        .wb_dat_r, .wb_ack, .fb_host_we, .fb_host_addr, .fb_host_idx,
        .pal_we, .pal_idx, .pal_colr, .fade_start, .fade_rate, .fade_idx
    );

    fizzle_fader fader_inst (
        .clk_sys, .rst_n, .fade_start, .fade_rate, .fade_idx,
        .fade_we, .fade_addr, .fade_wr_idx, .fade_busy
    );

    framebuffer_ram fb_inst (
        .clk_sys,
        .host_we   (fb_host_we),
        .host_addr (fb_host_addr),
        .host_idx  (fb_host_idx),
        .fade_we,
        .fade_addr,
        .fade_idx  (fade_wr_idx),
        .rd_addr   (fb_rd_addr),
        .rd_idx    (fb_idx)
    );

    line_scaler scaler_inst (
        .clk_sys, .rst_n, .sx, .sy, .de, .line_start, .frame_start,
        .fb_idx, .fb_rd_addr, .lb_idx, .lb_valid
    );

    palette_lut clut_inst (
        .clk_sys,
        .we        (pal_we),
        .wr_idx    (pal_idx),
        .wr_colr   (pal_colr),
        .rd_idx    (lb_idx),
        .rd_valid  (lb_valid),
        .host_idx  (pal_idx),
        .colr      (pix_colr),
        .host_colr (pal_rd_colr)
    );

    // output stage, third register of both paths
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hs_pipe   <= 2'b00;
            vs_pipe   <= 2'b00;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_r     <= 4'h0;
            vga_g     <= 4'h0;
            vga_b     <= 4'h0;
        end else begin
            hs_pipe   <= {hs_pipe[0], hsync};
            vs_pipe   <= {vs_pipe[0], vsync};
            vga_hsync <= hs_pipe[1];
            vga_vsync <= vs_pipe[1];
            vga_r     <= pix_colr.r;  // already black outside de
            vga_g     <= pix_colr.g;
            vga_b     <= pix_colr.b;
        end
    end

endmodule

`default_nettype wire

// File: logic/host_regs.sv
// ******************************
// wishbone classic slave, one wait state per transfer
// decodes control, palette and framebuffer regions
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module host_regs (
    input  wire logic                    clk_sys,
    input  wire logic                    rst_n,
    input  wire logic                    wb_cyc,
    input  wire logic                    wb_stb,
    input  wire logic                    wb_we,
    input  wire logic [`WB_ADRW-1:0]     wb_adr,
    input  wire fizzle_pkg::host_word_t  wb_dat_w,
    input  wire fizzle_pkg::colr_t       pal_rd_colr,
    output fizzle_pkg::host_word_t       wb_dat_r,
    output logic                         wb_ack,
    output logic                         fb_host_we,
    output fizzle_pkg::fb_addr_t         fb_host_addr,
    output fizzle_pkg::cidx_t            fb_host_idx,
    output logic                         pal_we,
    output fizzle_pkg::cidx_t            pal_idx,
    output fizzle_pkg::colr_t            pal_colr,
    output logic                         fade_start,
    output logic [11:0]                  fade_rate,
    output fizzle_pkg::cidx_t            fade_idx
);

    fizzle_pkg::host_word_t ctrl_q;    // control register
    fizzle_pkg::host_word_t rd_word;
    logic                   req;
    logic                   ctrl_sel;
    logic                   pal_sel;
    logic                   fb_sel;

    always_comb begin
        req      = wb_cyc && wb_stb && !wb_ack;   // no back-to-back acks
        ctrl_sel = (wb_adr == `REG_CTRL);
        pal_sel  = ((wb_adr & 8'hF0) == `PAL_BASE);
        fb_sel   = ((wb_adr & `FB_BASE) == `FB_BASE);
        // write strobes land on the edge that raises ack
        fb_host_we   = req && wb_we && fb_sel;
        fb_host_addr = wb_adr[`FB_ADDRW-1:0];
        fb_host_idx  = fizzle_pkg::cidx_t'(wb_dat_w[3:0]);  // pixel in low nibble
        pal_we       = req && wb_we && pal_sel;
        pal_idx      = wb_adr[3:0];
        pal_colr     = wb_dat_w.pal.colr;
        fade_rate    = ctrl_q.ctrl.rate;
        fade_idx     = ctrl_q.ctrl.idx;
        // read mux, framebuffer reads as zero
        rd_word = '0;
        if (ctrl_sel) begin
            rd_word = ctrl_q;
        end else if (pal_sel) begin
            rd_word.pal.colr = pal_rd_colr;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            fade_start <= 1'b0;
            ctrl_q     <= '0;
        end else begin
            wb_ack     <= req;
            fade_start <= req && wb_we && ctrl_sel;  // one pulse per write
            if (req && wb_we && ctrl_sel) begin
                ctrl_q <= wb_dat_w;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (req) begin
            wb_dat_r <= rd_word;  // valid in the ack cycle
        end
    end

endmodule

`default_nettype wire

// File: logic/palette_lut.sv
// ******************************
// 16 entry colour lookup, one cycle read
// host side writes and reads entries back
// ******************************
`default_nettype none
`timescale 1ns/1ns

module palette_lut (
    input  wire logic               clk_sys,
    input  wire logic               we,
    input  wire fizzle_pkg::cidx_t  wr_idx,
    input  wire fizzle_pkg::colr_t  wr_colr,
    input  wire fizzle_pkg::cidx_t  rd_idx,
    input  wire logic               rd_valid,
    input  wire fizzle_pkg::cidx_t  host_idx,
    output fizzle_pkg::colr_t       colr,
    output fizzle_pkg::colr_t       host_colr
);

    fizzle_pkg::colr_t pal [16];

    always_ff @(posedge clk_sys) begin
        if (we) begin
            pal[wr_idx] <= wr_colr;
        end
        colr <= rd_valid ? pal[rd_idx] : '0;  // black in blanking
    end

    // read-back for the bus, same cycle
    always_comb begin
        host_colr = pal[host_idx];
    end

endmodule

`default_nettype wire

// File: logic/line_scaler.sv
// ******************************
// ping-pong line buffer between framebuffer and palette
// fills the next fb row while the other half replays scaled
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module line_scaler (
    input  wire logic               clk_sys,
    input  wire logic               rst_n,
    input  wire logic [5:0]         sx,
    input  wire logic [5:0]         sy,
    input  wire logic               de,
    input  wire logic               line_start,
    input  wire logic               frame_start,
    input  wire fizzle_pkg::cidx_t  fb_idx,
    output fizzle_pkg::fb_addr_t    fb_rd_addr,
    output fizzle_pkg::cidx_t       lb_idx,
    output logic                    lb_valid
);

    localparam int COLW = $clog2(`FB_WIDTH);
    localparam int ROWW = $clog2(`FB_HEIGHT);
    localparam int REPW = $clog2(`FB_SCALE + 1);

    fizzle_pkg::cidx_t line_buf [2*`FB_WIDTH];   // two halves picked by the msb
    logic              disp_half;                // half on screen
    logic              fill_half;                // half being loaded
    logic              fill_on;
    logic [COLW:0]     fill_cnt;                 // 0 .. FB_WIDTH
    logic [ROWW-1:0]   fill_row;
    logic              wr_on;                    // ram data valid this cycle
    logic [COLW-1:0]   wr_col;
    logic [REPW-1:0]   rep_cnt;                  // line within row group
    logic              new_group;
    logic [5:0]        row_now;
    logic [COLW-1:0]   rd_col;

    always_comb begin
        row_now    = sy / 6'(`FB_SCALE);          // fb row of this screen line
        rd_col     = COLW'(sx / 6'(`FB_SCALE));
        new_group  = line_start && (sy < 6'(`V_ACTIVE))
                     && (frame_start || rep_cnt == REPW'(`FB_SCALE - 1));
        fb_rd_addr = fizzle_pkg::fb_addr_t'(fill_row * `FB_WIDTH + fill_cnt[COLW-1:0]);
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            disp_half <= 1'b0;
            fill_half <= 1'b1;
            fill_on   <= 1'b0;
            fill_cnt  <= '0;
            fill_row  <= '0;
            rep_cnt   <= '0;
            wr_on     <= 1'b0;
            lb_valid  <= 1'b0;
        end else begin
            lb_valid <= de;                       // replay lags de by one
            wr_on    <= fill_on && (fill_cnt < (COLW+1)'(`FB_WIDTH));
            if (line_start) begin
                rep_cnt <= (frame_start || rep_cnt == REPW'(`FB_SCALE - 1))
                           ? '0 : rep_cnt + 1'b1;
            end
            if (new_group) begin
                disp_half <= ~disp_half;          // swap every FB_SCALE lines
                fill_half <= disp_half;           // old screen half is free
            end
            if (new_group && row_now < 6'(`FB_HEIGHT - 1)) begin
                fill_on  <= 1'b1;                 // preload row k+1
                fill_cnt <= '0;
                fill_row <= ROWW'(row_now + 6'd1);
            end else if (line_start && sy == 6'(`V_ACTIVE)) begin
                fill_on   <= 1'b1;                // row 0 during vblank
                fill_cnt  <= '0;
                fill_row  <= '0;
                fill_half <= ~disp_half;
            end else if (fill_on) begin
                fill_cnt <= fill_cnt + 1'b1;
                if (fill_cnt == (COLW+1)'(`FB_WIDTH)) begin
                    fill_on <= 1'b0;              // FB_WIDTH+1 cycles total
                end
            end
        end
    end

    // buffer storage
    always_ff @(posedge clk_sys) begin
        wr_col <= fill_cnt[COLW-1:0];
        if (wr_on) begin
            line_buf[{fill_half, wr_col}] <= fb_idx;
        end
        lb_idx <= line_buf[{disp_half ^ new_group, rd_col}];  // new half from pixel 0 on
    end

endmodule

`default_nettype wire

// File: logic/fizzle_fader.sv
// ******************************
// fizzlefade walker, lfsr picks the next pixel
// runs once per fade_start until the lfsr is back at its seed
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module fizzle_fader (
    input  wire logic               clk_sys,
    input  wire logic               rst_n,
    input  wire logic               fade_start,
    input  wire logic [11:0]        fade_rate,
    input  wire fizzle_pkg::cidx_t  fade_idx,
    output logic                    fade_we,
    output fizzle_pkg::fb_addr_t    fade_addr,
    output fizzle_pkg::cidx_t       fade_wr_idx,   // fade colour for the write port
    output logic                    fade_busy
);

    localparam fizzle_pkg::fb_addr_t SEED = 1;     // zero would lock the lfsr

    fizzle_pkg::host_word_t ctrl_q;    // settings held for the whole fade
    fizzle_pkg::fb_addr_t   lfsr;
    fizzle_pkg::fb_addr_t   lfsr_nxt;
    logic [11:0]            rate_cnt;
    logic                   step;

    always_comb begin
        // fibonacci form, shift left and feed the xor in at bit 0
        lfsr_nxt    = {lfsr[`FB_ADDRW-2:0], ^(lfsr & `LFSR_TAPS)};
        step        = fade_busy && !fade_start && (rate_cnt == ctrl_q.ctrl.rate);
        fade_wr_idx = ctrl_q.ctrl.idx;
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            fade_busy <= 1'b0;
            fade_we   <= 1'b0;
            lfsr      <= SEED;
            rate_cnt  <= 12'd0;
        end else begin
            fade_we <= step;
            if (fade_start) begin      // restart, even mid fade
                fade_busy <= 1'b1;
                lfsr      <= SEED;
                rate_cnt  <= 12'd0;
            end else if (step) begin
                rate_cnt <= 12'd0;
                lfsr     <= lfsr_nxt;
                if (lfsr_nxt == SEED) begin
                    fade_busy <= 1'b0;  // all 2^n-1 addresses done
                end
            end else if (fade_busy) begin
                rate_cnt <= rate_cnt + 12'd1;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk_sys) begin
        if (fade_start) begin
            ctrl_q.ctrl.idx  <= fade_idx;
            ctrl_q.ctrl.rate <= fade_rate;
        end
        if (step) begin
            fade_addr <= lfsr;  // write at current value, then advance
        end
    end

endmodule

`default_nettype wire

// File: logic/framebuffer_ram.sv
// ******************************
// colour index framebuffer, registered read
// host write port has priority over the fader
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module framebuffer_ram (
    input  wire logic                 clk_sys,
    input  wire logic                 host_we,
    input  wire fizzle_pkg::fb_addr_t host_addr,
    input  wire fizzle_pkg::cidx_t    host_idx,
    input  wire logic                 fade_we,
    input  wire fizzle_pkg::fb_addr_t fade_addr,
    input  wire fizzle_pkg::cidx_t    fade_idx,
    input  wire fizzle_pkg::fb_addr_t rd_addr,
    output fizzle_pkg::cidx_t         rd_idx
);

    fizzle_pkg::cidx_t mem [2**`FB_ADDRW];

    // single physical write port, fader loses on a clash
    always_ff @(posedge clk_sys) begin
        if (host_we) begin
            mem[host_addr] <= host_idx;
        end else if (fade_we) begin
            mem[fade_addr] <= fade_idx;
        end
        rd_idx <= mem[rd_addr];  // one cycle read
    end

endmodule

`default_nettype wire

// File: logic/display_timing.sv
// ******************************
// screen position counters and sync generation
// one pixel per clk_sys cycle
// ******************************
`default_nettype none
`timescale 1ns/1ns

`include "fizzle_macros.svh"

module display_timing (
    input  wire logic       clk_sys,
    input  wire logic       rst_n,
    output logic [5:0]      sx,
    output logic [5:0]      sy,
    output logic            de,
    output logic            hsync,
    output logic            vsync,
    output logic            line_start,
    output logic            frame_start
);

    // pixel and line counters over the whole frame
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            sx <= 6'd0;
            sy <= 6'd0;
        end else if (sx == 6'(`H_TOTAL - 1)) begin
            sx <= 6'd0;
            sy <= (sy == 6'(`V_TOTAL - 1)) ? 6'd0 : sy + 6'd1;
        end else begin
            sx <= sx + 6'd1;
        end
    end

    // decodes straight off the counters
    always_comb begin
        de          = (sx < 6'(`H_ACTIVE)) && (sy < 6'(`V_ACTIVE));
        hsync       = (sx >= 6'(`H_SYNC_START)) && (sx < 6'(`H_SYNC_END));  // active high
        vsync       = (sy >= 6'(`V_SYNC_START)) && (sy < 6'(`V_SYNC_END));
        line_start  = (sx == 6'd0);                  // first cycle after wrap
        frame_start = (sx == 6'd0) && (sy == 6'd0);
    end

endmodule

`default_nettype wire

// File: logic/fizzle_pkg.sv
// ******************************
// shared types for the fizzlefade display
// referenced by scoped name from the RTL and testbench
// ******************************
`default_nettype none

`include "fizzle_macros.svh"

package fizzle_pkg;

    typedef logic [3:0] cidx_t;                 // colour index

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colr_t;                                   // 12-bit rgb

    typedef logic [`FB_ADDRW-1:0] fb_addr_t;    // pixel address, row major

    // one bus word, two meanings picked by address
    typedef union packed {
        struct packed {
            logic [3:0] unused;
            colr_t      colr;
        } pal;                                  // palette region
        struct packed {
            cidx_t       idx;                   // fade colour
            logic [11:0] rate;                  // cycles per step minus one
        } ctrl;                                 // control register
    } host_word_t;

endpackage

`default_nettype wire

// File: logic/fizzle_macros.svh
// ******************************
// geometry, timing and register map of the fizzlefade display
// included by the package and by the RTL that needs these numbers
// ******************************
`ifndef FIZZLE_MACROS_SVH
`define FIZZLE_MACROS_SVH

// framebuffer
`define FB_WIDTH      16
`define FB_HEIGHT     8
`define FB_SCALE      2           // screen pixels per fb pixel, both axes
`define FB_ADDRW      7           // also the lfsr length
`define LFSR_TAPS     7'b1100000  // x^7 + x^6 + 1, maximal length

// horizontal timing, in cycles
`define H_ACTIVE      32
`define H_SYNC_START  36
`define H_SYNC_END    40
`define H_TOTAL       44

// vertical timing, in lines
`define V_ACTIVE      16
`define V_SYNC_START  17
`define V_SYNC_END    19
`define V_TOTAL       20

// wishbone map
`define WB_ADRW       8
`define REG_CTRL      8'h00       // fade control word
`define PAL_BASE      8'h10       // 16 palette words
`define FB_BASE       8'h80       // 128 pixels, write only

`endif
